// ==== logic/lsu_pkg.sv ====
package lsu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [3:0]  lane_sel_t;

	typedef enum logic [3:0] {
		OP_NONE,
		OP_ORI,
		OP_LUI,
		OP_LB,
		OP_LBU,
		OP_LH,
		OP_LHU,
		OP_LW,
		OP_LWL,
		OP_LWR,
		OP_LL,
		OP_SB,
		OP_SH,
		OP_SW,
		OP_SC
	} oper_t;

	// MIPS primary opcodes, instr[31:26].
	localparam logic [5:0] OPC_ORI = 6'h0d;
	localparam logic [5:0] OPC_LUI = 6'h0f;
	localparam logic [5:0] OPC_LB  = 6'h20;
	localparam logic [5:0] OPC_LH  = 6'h21;
	localparam logic [5:0] OPC_LWL = 6'h22;
	localparam logic [5:0] OPC_LW  = 6'h23;
	localparam logic [5:0] OPC_LBU = 6'h24;
	localparam logic [5:0] OPC_LHU = 6'h25;
	localparam logic [5:0] OPC_LWR = 6'h26;
	localparam logic [5:0] OPC_SB  = 6'h28;
	localparam logic [5:0] OPC_SH  = 6'h29;
	localparam logic [5:0] OPC_SW  = 6'h2b;
	localparam logic [5:0] OPC_LL  = 6'h30;
	localparam logic [5:0] OPC_SC  = 6'h38;

endpackage

// ==== logic/lsu_decode.sv ====
`timescale 1ns/1ps

module lsu_decode (
	input  logic               clk,
	input  logic               rst,
	input  logic               valid_i,
	input  lsu_pkg::word_t     instr_i,
	input  lsu_pkg::word_t     rs_data_i,
	input  lsu_pkg::word_t     rt_data_i,
	input  logic               fwd_we_i,
	input  lsu_pkg::reg_idx_t  fwd_addr_i,
	input  lsu_pkg::word_t     fwd_data_i,
	output lsu_pkg::reg_idx_t  rs_addr_o,
	output lsu_pkg::reg_idx_t  rt_addr_o,
	output lsu_pkg::oper_t     op_o,
	output logic               mem_ce_o,
	output logic               mem_we_o,
	output lsu_pkg::word_t     mem_addr_o,
	output lsu_pkg::lane_sel_t mem_sel_o,
	output lsu_pkg::word_t     mem_wdata_o,
	output logic               wr_we_o,
	output lsu_pkg::reg_idx_t  wr_addr_o,
	output lsu_pkg::word_t     wr_data_o
);

lsu_pkg::oper_t     op;
lsu_pkg::word_t     rs_val, rt_val, addr, wdata, wr_data;
lsu_pkg::lane_sel_t sel;
logic               is_load, is_store, wr_we;
logic [15:0]        imm;

assign rs_addr_o = instr_i[25:21];
assign rt_addr_o = instr_i[20:16];
assign imm       = instr_i[15:0];

// Result still in the memory stage wins over the register file.
assign rs_val = (fwd_we_i && fwd_addr_i != '0 && fwd_addr_i == rs_addr_o) ?
	fwd_data_i : rs_data_i;
assign rt_val = (fwd_we_i && fwd_addr_i != '0 && fwd_addr_i == rt_addr_o) ?
	fwd_data_i : rt_data_i;

always_comb begin
	op = lsu_pkg::OP_NONE;
	if (valid_i) begin
		case (instr_i[31:26])
			lsu_pkg::OPC_ORI: op = lsu_pkg::OP_ORI;
			lsu_pkg::OPC_LUI: op = lsu_pkg::OP_LUI;
			lsu_pkg::OPC_LB:  op = lsu_pkg::OP_LB;
			lsu_pkg::OPC_LBU: op = lsu_pkg::OP_LBU;
			lsu_pkg::OPC_LH:  op = lsu_pkg::OP_LH;
			lsu_pkg::OPC_LHU: op = lsu_pkg::OP_LHU;
			lsu_pkg::OPC_LW:  op = lsu_pkg::OP_LW;
			lsu_pkg::OPC_LWL: op = lsu_pkg::OP_LWL;
			lsu_pkg::OPC_LWR: op = lsu_pkg::OP_LWR;
			lsu_pkg::OPC_LL:  op = lsu_pkg::OP_LL;
			lsu_pkg::OPC_SB:  op = lsu_pkg::OP_SB;
			lsu_pkg::OPC_SH:  op = lsu_pkg::OP_SH;
			lsu_pkg::OPC_SW:  op = lsu_pkg::OP_SW;
			lsu_pkg::OPC_SC:  op = lsu_pkg::OP_SC;
			default:          op = lsu_pkg::OP_NONE;
		endcase
	end
end

assign is_load = op inside {lsu_pkg::OP_LB, lsu_pkg::OP_LBU, lsu_pkg::OP_LH,
	lsu_pkg::OP_LHU, lsu_pkg::OP_LW, lsu_pkg::OP_LWL, lsu_pkg::OP_LWR, lsu_pkg::OP_LL};
assign is_store = op inside {lsu_pkg::OP_SB, lsu_pkg::OP_SH, lsu_pkg::OP_SW,
	lsu_pkg::OP_SC};
assign wr_we = is_load || op inside {lsu_pkg::OP_ORI, lsu_pkg::OP_LUI, lsu_pkg::OP_SC};

assign addr = rs_val + {{16{imm[15]}}, imm};

always_comb begin
	sel   = 4'b1111;
	wdata = rt_val;
	case (op)
		lsu_pkg::OP_LB, lsu_pkg::OP_LBU, lsu_pkg::OP_SB: begin
			sel   = 4'b0001 << addr[1:0];
			wdata = {4{rt_val[7:0]}};
		end
		lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH: begin
			sel   = addr[1] ? 4'b1100 : 4'b0011;
			wdata = {2{rt_val[15:0]}};
		end
		lsu_pkg::OP_LWL: sel = 4'b1111 << addr[1:0];
		lsu_pkg::OP_LWR: sel = 4'b1111 >> (2'd3 - addr[1:0]);
		default: ;
	endcase
end

// Loads carry old rt for the LWL/LWR merge.
always_comb begin
	case (op)
		lsu_pkg::OP_ORI: wr_data = rs_val | {16'b0, imm};
		lsu_pkg::OP_LUI: wr_data = {imm, 16'b0};
		default:         wr_data = rt_val;
	endcase
end

always_ff @(posedge clk) begin
	if (rst) begin
		op_o     <= lsu_pkg::OP_NONE;
		mem_ce_o <= 1'b0;
		mem_we_o <= 1'b0;
		wr_we_o  <= 1'b0;
	end else begin
		op_o     <= op;
		mem_ce_o <= is_load || is_store;
		mem_we_o <= is_store;
		wr_we_o  <= wr_we;
	end
end

always_ff @(posedge clk) begin
	mem_addr_o  <= addr;
	mem_sel_o   <= sel;
	mem_wdata_o <= wdata;
	wr_addr_o   <= rt_addr_o;
	wr_data_o   <= wr_data;
end

a_mem_sel: assert property (@(posedge clk) disable iff (rst)
	mem_ce_o |-> mem_sel_o != '0)
	else $error("memory access with empty lane mask");

endmodule

// ==== logic/lsu_regfile.sv ====
`timescale 1ns/1ps

module lsu_regfile (
	input  logic              clk,
	input  logic              rst,
	input  lsu_pkg::reg_idx_t rs_addr_i,
	input  lsu_pkg::reg_idx_t rt_addr_i,
	output lsu_pkg::word_t    rs_data_o,
	output lsu_pkg::word_t    rt_data_o,
	input  logic              we_i,
	input  lsu_pkg::reg_idx_t waddr_i,
	input  lsu_pkg::word_t    wdata_i
);

lsu_pkg::word_t regs [32];

// Write in the same cycle is seen by the reader.
function automatic lsu_pkg::word_t read_port(input lsu_pkg::reg_idx_t addr);
	if (addr == '0) begin
		return '0;
	end
	if (we_i && waddr_i == addr) begin
		return wdata_i;
	end
	return regs[addr];
endfunction

always_comb begin
	rs_data_o = read_port(rs_addr_i);
	rt_data_o = read_port(rt_addr_i);
end

always_ff @(posedge clk) begin
	if (rst) begin
		for (int i = 0; i < 32; i++) begin
			regs[i] <= '0;
		end
	end else if (we_i && waddr_i != '0) begin
		regs[waddr_i] <= wdata_i;
	end
end

endmodule

// ==== logic/lsu_mem_stage.sv ====
`timescale 1ns/1ps

module lsu_mem_stage (
	input  logic               rst,
	input  lsu_pkg::oper_t     op_i,
	input  logic               ll_bit_i,
	input  logic               mem_ce_i,
	input  logic               mem_we_i,
	input  lsu_pkg::word_t     mem_addr_i,
	input  lsu_pkg::lane_sel_t mem_sel_i,
	input  lsu_pkg::word_t     mem_wdata_i,
	input  logic               wr_we_i,
	input  lsu_pkg::reg_idx_t  wr_addr_i,
	input  lsu_pkg::word_t     wr_data_i,
	input  lsu_pkg::word_t     ram_rdata_i,
	output lsu_pkg::word_t     ram_addr_o,
	output logic               ram_read_o,
	output logic               ram_write_o,
	output lsu_pkg::word_t     ram_wdata_o,
	output lsu_pkg::lane_sel_t ram_mask_o,
	output logic               res_we_o,
	output lsu_pkg::reg_idx_t  res_addr_o,
	output lsu_pkg::word_t     res_data_o
);

lsu_pkg::word_t byte_rd, half_rd, ext_sel, merged;

// Move the addressed lane down to bit 0.
assign byte_rd = ram_rdata_i >> {mem_addr_i[1:0], 3'b000};
assign half_rd = ram_rdata_i >> {mem_addr_i[1], 4'b0000};

assign ext_sel = {
	{8{mem_sel_i[3]}},
	{8{mem_sel_i[2]}},
	{8{mem_sel_i[1]}},
	{8{mem_sel_i[0]}}
};
assign merged = (wr_data_i & ~ext_sel) | (ram_rdata_i & ext_sel);

always_comb begin
	ram_addr_o  = '0;
	ram_read_o  = 1'b0;
	ram_write_o = 1'b0;
	ram_wdata_o = '0;
	ram_mask_o  = '0;
	res_we_o    = 1'b0;
	res_addr_o  = '0;
	res_data_o  = '0;
	if (!rst && mem_ce_i) begin
		ram_addr_o = mem_addr_i;
		ram_mask_o = mem_sel_i;
		if (mem_we_i) begin
			ram_write_o = 1'b1;
			ram_wdata_o = mem_wdata_i;
			if (op_i == lsu_pkg::OP_SC) begin
				// SC succeeds only while the link holds.
				ram_write_o = ll_bit_i;
				res_we_o    = wr_we_i;
				res_addr_o  = wr_addr_i;
				res_data_o  = {31'b0, ll_bit_i};
			end
		end else begin
			ram_read_o = 1'b1;
			res_we_o   = 1'b1;
			res_addr_o = wr_addr_i;
			case (op_i)
				lsu_pkg::OP_LB:  res_data_o = {{24{byte_rd[7]}}, byte_rd[7:0]};
				lsu_pkg::OP_LBU: res_data_o = {24'b0, byte_rd[7:0]};
				lsu_pkg::OP_LH:  res_data_o = {{16{half_rd[15]}}, half_rd[15:0]};
				lsu_pkg::OP_LHU: res_data_o = {16'b0, half_rd[15:0]};
				lsu_pkg::OP_LWL, lsu_pkg::OP_LWR: res_data_o = merged;
				default:         res_data_o = ram_rdata_i;
			endcase
		end
	end else if (!rst) begin
		res_we_o   = wr_we_i;
		res_addr_o = wr_addr_i;
		res_data_o = wr_data_i;
	end
end

endmodule

// ==== logic/lsu_data_ram.sv ====
`timescale 1ns/1ps

module lsu_data_ram #(
	parameter int unsigned MEM_WORDS = 256
) (
	input  logic               clk,
	input  logic               rst,
	input  lsu_pkg::word_t     addr_i,
	input  logic               read_i,
	input  logic               write_i,
	input  lsu_pkg::word_t     wdata_i,
	input  lsu_pkg::lane_sel_t mask_i,
	output lsu_pkg::word_t     rdata_o
);

lsu_pkg::word_t mem [MEM_WORDS];
logic [31:0]    idx;

// Byte address to word index, wrapped to the array size.
assign idx = {2'b00, addr_i[31:2]} % MEM_WORDS;

assign rdata_o = read_i ? mem[idx] : '0;

always_ff @(posedge clk) begin
	if (rst) begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] <= '0;
		end
	end else if (write_i) begin
		for (int k = 0; k < 4; k++) begin
			if (mask_i[k]) begin
				mem[idx][8*k +: 8] <= wdata_i[8*k +: 8];
			end
		end
	end
end

a_write_mask: assert property (@(posedge clk) disable iff (rst)
	write_i |-> mask_i != '0)
	else $error("RAM write with zero mask");

endmodule

// ==== logic/lsu_writeback.sv ====
`timescale 1ns/1ps

module lsu_writeback (
	input  logic              clk,
	input  logic              rst,
	input  lsu_pkg::oper_t    op_i,
	input  logic              res_we_i,
	input  lsu_pkg::reg_idx_t res_addr_i,
	input  lsu_pkg::word_t    res_data_i,
	output logic              rf_we_o,
	output lsu_pkg::reg_idx_t rf_waddr_o,
	output lsu_pkg::word_t    rf_wdata_o,
	output logic              ll_bit_o
);

// Writes to r0 pass on; the register file drops them.
always_ff @(posedge clk) begin
	if (rst) begin
		rf_we_o  <= 1'b0;
		ll_bit_o <= 1'b0;
	end else begin
		rf_we_o <= res_we_i;
		if (op_i == lsu_pkg::OP_LL) begin
			ll_bit_o <= 1'b1;
		end else if (op_i == lsu_pkg::OP_SC) begin
			ll_bit_o <= 1'b0;
		end
	end
end

always_ff @(posedge clk) begin
	rf_waddr_o <= res_addr_i;
	rf_wdata_o <= res_data_i;
end

endmodule

// ==== logic/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top #(
	parameter int unsigned MEM_WORDS = 256
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              instr_valid_i,
	input  lsu_pkg::word_t    instr_i,
	output logic              wb_we_o,
	output lsu_pkg::reg_idx_t wb_addr_o,
	output lsu_pkg::word_t    wb_data_o
);

lsu_pkg::reg_idx_t  rs_addr, rt_addr, wr_addr, res_addr;
lsu_pkg::word_t     rs_data, rt_data, mem_addr, mem_wdata, wr_data, res_data;
lsu_pkg::word_t     ram_addr, ram_wdata, ram_rdata;
lsu_pkg::lane_sel_t mem_sel, ram_mask;
lsu_pkg::oper_t     op;
logic               mem_ce, mem_we, wr_we, res_we, ram_read, ram_write, ll_bit;

lsu_decode u_decode (
	.clk(clk), .rst(rst), .valid_i(instr_valid_i), .instr_i(instr_i),
	.rs_data_i(rs_data), .rt_data_i(rt_data),
	.fwd_we_i(res_we), .fwd_addr_i(res_addr), .fwd_data_i(res_data),
	.rs_addr_o(rs_addr), .rt_addr_o(rt_addr), .op_o(op),
	.mem_ce_o(mem_ce), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
	.mem_sel_o(mem_sel), .mem_wdata_o(mem_wdata),
	.wr_we_o(wr_we), .wr_addr_o(wr_addr), .wr_data_o(wr_data)
);

lsu_regfile u_regfile (
	.clk(clk), .rst(rst), .rs_addr_i(rs_addr), .rt_addr_i(rt_addr),
	.rs_data_o(rs_data), .rt_data_o(rt_data),
	.we_i(wb_we_o), .waddr_i(wb_addr_o), .wdata_i(wb_data_o)
);

lsu_mem_stage u_mem_stage (
	.rst(rst), .op_i(op), .ll_bit_i(ll_bit),
	.mem_ce_i(mem_ce), .mem_we_i(mem_we), .mem_addr_i(mem_addr),
	.mem_sel_i(mem_sel), .mem_wdata_i(mem_wdata),
	.wr_we_i(wr_we), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
	.ram_rdata_i(ram_rdata), .ram_addr_o(ram_addr), .ram_read_o(ram_read),
	.ram_write_o(ram_write), .ram_wdata_o(ram_wdata), .ram_mask_o(ram_mask),
	.res_we_o(res_we), .res_addr_o(res_addr), .res_data_o(res_data)
);

lsu_data_ram #(.MEM_WORDS(MEM_WORDS)) u_data_ram (
	.clk(clk), .rst(rst), .addr_i(ram_addr), .read_i(ram_read),
	.write_i(ram_write), .wdata_i(ram_wdata), .mask_i(ram_mask),
	.rdata_o(ram_rdata)
);

lsu_writeback u_writeback (
	.clk(clk), .rst(rst), .op_i(op),
	.res_we_i(res_we), .res_addr_i(res_addr), .res_data_i(res_data),
	.rf_we_o(wb_we_o), .rf_waddr_o(wb_addr_o), .rf_wdata_o(wb_data_o),
	.ll_bit_o(ll_bit)
);

endmodule

// ==== test/tb_lsu.sv ====
`timescale 1ns/1ps

module tb_lsu;

localparam int MAX_VEC = 64;

logic        clk;
logic        rst;
logic        instr_valid_i;
logic [31:0] instr_i;
logic        wb_we_o;
logic [4:0]  wb_addr_o;
logic [31:0] wb_data_o;

logic [75:0] vectors [MAX_VEC];
logic [75:0] pending [$];
int          num_vec;
int          errors;
integer      seed;
logic        loaded;

lsu_top #(.MEM_WORDS(256)) u_lsu_top (
	.clk(clk), .rst(rst), .instr_valid_i(instr_valid_i), .instr_i(instr_i),
	.wb_we_o(wb_we_o), .wb_addr_o(wb_addr_o), .wb_data_o(wb_data_o)
);

initial begin
	clk = 1'b0;
	forever #20 clk = ~clk;
end

task automatic check_result(input logic [75:0] v);
	logic        exp_we;
	logic [4:0]  exp_addr;
	logic [31:0] exp_data;
	exp_we   = v[40];
	exp_addr = v[36:32];
	exp_data = v[31:0];
	if (wb_we_o !== exp_we) begin
		$display("ERR wb_we_o got %h expected %h", wb_we_o, exp_we);
		errors++;
	end else if (exp_we) begin
		if (wb_addr_o !== exp_addr) begin
			$display("ERR wb_addr_o got %h expected %h", wb_addr_o, exp_addr);
			errors++;
		end
		if (wb_data_o !== exp_data) begin
			$display("ERR wb_data_o got %h expected %h", wb_data_o, exp_data);
			errors++;
		end
	end
endtask

// Result of a slot shows two edges after it is driven.
task automatic issue(input logic valid, input logic [75:0] v);
	@(posedge clk);
	#2;
	if (pending.size() == 2) begin
		check_result(pending.pop_front());
	end
	instr_valid_i = valid;
	instr_i       = v[75:44];
	pending.push_back(valid ? v : 76'h0);
endtask

initial begin
	loaded        = 1'b0;
	rst           = 1'b1;
	instr_valid_i = 1'b0;
	instr_i       = '0;
	errors        = 0;
	seed          = 32'hee45_8c7a;
	$readmemh("test/lsu_stimulus.txt", vectors);
	num_vec = 0;
	while (num_vec < MAX_VEC && !$isunknown(vectors[num_vec])) begin
		num_vec++;
	end
	loaded = 1'b1;
	repeat (2) @(posedge clk);
	#2;
	rst = 1'b0;
	if (num_vec == 0) begin
		$display("No stimulus vectors could be loaded from the data file");
		errors++;
	end
	for (int i = 0; i < num_vec; i++) begin
		// Occasional bubble.
		if ($random(seed) % 6 == 0) begin
			issue(1'b0, 76'h0);
		end
		issue(1'b1, vectors[i]);
	end
	repeat (2) issue(1'b0, 76'h0);
	$display("tb_lsu: %0d errors over %0d vectors", errors, num_vec);
	if (errors == 0) begin
		$display("Test OK");
	end else begin
		$display("Test FAILED");
	end
	$finish;
end

// At most one bubble per vector, plus reset and drain.
initial begin
	wait (loaded === 1'b1);
	#(40 * (2 * num_vec + 24));
	$display("Timeout: the run did not finish in the expected number of cycles");
	$display("Test FAILED");
	$finish;
end

endmodule

// ==== list.f ====
logic/lsu_pkg.sv
logic/lsu_decode.sv
logic/lsu_regfile.sv
logic/lsu_mem_stage.sv
logic/lsu_data_ram.sv
logic/lsu_writeback.sv
logic/lsu_top.sv
test/tb_lsu.sv

// ==== test/lsu_stimulus.txt ====
// Columns joined by underscores: instruction, expected wb_we_o, wb_addr_o, wb_data_o.
// A store or idle slot expects wb_we_o low and leaves address and data unchecked.
34011234_1_01_00001234
34225600_1_02_00005634
34230001_1_03_00001235
3C04A5C3_1_04_a5c30000
34847E81_1_04_a5c37e81
// Word, byte and half-word stores, then read back.
AC040040_0_00_00000000
8C050040_1_05_a5c37e81
A0010041_0_00_00000000
A4020042_0_00_00000000
8C060040_1_06_56343481
AC040080_0_00_00000000
// Byte and half-word loads of a5c37e81.
80070080_1_07_ffffff81
80070081_1_07_0000007e
80070082_1_07_ffffffc3
80070083_1_07_ffffffa5
90080080_1_08_00000081
90080081_1_08_0000007e
90080082_1_08_000000c3
90080083_1_08_000000a5
84090080_1_09_00007e81
84090082_1_09_ffffa5c3
940A0080_1_0a_00007e81
940A0082_1_0a_0000a5c3
// Unaligned word merge.
3C0B1122_1_0b_11220000
356B3344_1_0b_11223344
880B0081_1_0b_a5c37e44
98030082_1_03_00c37e81
// Linked pair, failing SC, then memory check.
C00C00C0_1_0c_00000000
E00100C0_1_01_00000001
E00200C0_1_02_00000000
8C0D00C0_1_0d_00001234
// Untouched word and r0 write.
8C0E03FC_1_0e_00000000
34005555_1_00_00005555
340F00AA_1_0f_000000aa
